//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // What happens to an instruction after the ALU
  typedef enum logic [3:0] {
    KIND_ALU,
    KIND_LUI,
    KIND_AUIPC,
    KIND_JAL,
    KIND_JALR,
    KIND_BRANCH,
    KIND_LOAD,
    KIND_STORE,
    KIND_HALT
  } instr_kind_e;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

//--- gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file import cpu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  reg_idx_t  raddr1,
  input  reg_idx_t  raddr2,
  input  wire logic wen,
  input  reg_idx_t  waddr,
  input  word_t     wdata,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [32];

  // x0 is cleared by reset and never written, so it always reads zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic commit_valid,
  input  word_t     commit_pc,
  input  wire logic commit_halt,
  output logic      mem_req_valid,
  input  wire logic mem_req_ready,
  output word_t     mem_req_addr,
  input  wire logic mem_resp_valid,
  input  word_t     mem_resp_rdata,
  output logic      out_valid,
  input  wire logic out_ready,
  output word_t     out_pc,
  output word_t     out_instr,
  output logic      halted
);

  typedef enum logic [2:0] {
    F_IDLE,
    F_REQ,
    F_WAIT,
    F_OUT,
    F_COMMIT,
    F_HALT
  } fetch_state_e;

  fetch_state_e state;
  word_t        pc;
  word_t        instr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= F_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        F_IDLE: state <= F_REQ;
        F_REQ: begin
          if (mem_req_ready) state <= F_WAIT;
        end
        F_WAIT: begin
          if (mem_resp_valid) state <= F_OUT;
        end
        F_OUT: begin
          if (out_ready) state <= F_COMMIT;
        end
        F_COMMIT: begin
          // Only one instruction in flight, so wait here for its commit
          if (commit_valid) begin
            if (commit_halt) begin
              state <= F_HALT;
            end else begin
              pc    <= commit_pc;
              state <= F_REQ;
            end
          end
        end
        default: state <= F_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_WAIT && mem_resp_valid) instr <= mem_resp_rdata;
  end

  assign mem_req_valid = (state == F_REQ);
  assign mem_req_addr  = pc;
  assign out_valid     = (state == F_OUT);
  assign out_pc        = pc;
  assign out_instr     = instr;
  assign halted        = (state == F_HALT);

endmodule

`default_nettype wire

//--- decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import cpu_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  word_t       in_pc,
  input  word_t       in_instr,
  output reg_idx_t    raddr1,
  output reg_idx_t    raddr2,
  input  word_t       rdata1,
  input  word_t       rdata2,
  output logic        out_valid,
  input  wire logic   out_ready,
  output word_t       out_pc,
  output instr_kind_e out_kind,
  output alu_op_e     out_alu_op,
  output logic [2:0]  out_funct3,
  output word_t       out_rs1_val,
  output word_t       out_rs2_val,
  output word_t       out_imm,
  output logic        out_use_imm,
  output reg_idx_t    out_rd
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic        alt;
  word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  instr_kind_e kind;
  alu_op_e     alu_op;
  word_t       imm;
  logic        use_imm;
  logic        accept;

  assign opcode = in_instr[6:0];
  assign funct3 = in_instr[14:12];
  assign alt    = in_instr[30];
  assign raddr1 = in_instr[19:15];
  assign raddr2 = in_instr[24:20];

  assign imm_i = {{20{in_instr[31]}}, in_instr[31:20]};
  assign imm_s = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
  assign imm_b = {{19{in_instr[31]}}, in_instr[31], in_instr[7], in_instr[30:25],
                  in_instr[11:8], 1'b0};
  assign imm_u = {in_instr[31:12], 12'b0};
  assign imm_j = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12], in_instr[20],
                  in_instr[30:21], 1'b0};

  always_comb begin
    kind    = KIND_HALT;
    alu_op  = ALU_ADD;
    imm     = imm_i;
    use_imm = 1'b1;
    case (opcode)
      OPC_LUI:   begin kind = KIND_LUI;   imm = imm_u; end
      OPC_AUIPC: begin kind = KIND_AUIPC; imm = imm_u; end
      OPC_JAL:   begin kind = KIND_JAL;   imm = imm_j; end
      OPC_JALR:  kind = KIND_JALR;
      OPC_BRANCH: begin
        kind    = KIND_BRANCH;
        imm     = imm_b;
        use_imm = 1'b0;
      end
      OPC_LOAD:  kind = KIND_LOAD;
      OPC_STORE: begin kind = KIND_STORE; imm = imm_s; end
      OPC_OPIMM, OPC_OP: begin
        kind    = KIND_ALU;
        use_imm = (opcode == OPC_OPIMM);
        case (funct3)
          3'b000:  alu_op = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
          3'b001:  alu_op = ALU_SLL;
          3'b010:  alu_op = ALU_SLT;
          3'b011:  alu_op = ALU_SLTU;
          3'b100:  alu_op = ALU_XOR;
          3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
          3'b110:  alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      // EBREAK, and anything unsupported, halts the core
      OPC_SYSTEM: kind = KIND_HALT;
      default:    kind = KIND_HALT;
    endcase
  end

  assign in_ready = !out_valid;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_pc      <= in_pc;
      out_kind    <= kind;
      out_alu_op  <= alu_op;
      out_funct3  <= funct3;
      out_rs1_val <= rdata1;
      out_rs2_val <= rdata2;
      out_imm     <= imm;
      out_use_imm <= use_imm;
      out_rd      <= in_instr[11:7];
    end
  end

endmodule

`default_nettype wire

//--- execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  word_t       in_pc,
  input  instr_kind_e in_kind,
  input  alu_op_e     in_alu_op,
  input  wire [2:0]   in_funct3,
  input  word_t       in_rs1_val,
  input  word_t       in_rs2_val,
  input  word_t       in_imm,
  input  wire logic   in_use_imm,
  input  reg_idx_t    in_rd,
  output logic        out_valid,
  input  wire logic   out_ready,
  output instr_kind_e out_kind,
  output reg_idx_t    out_rd,
  output word_t       out_result,
  output word_t       out_store_data,
  output word_t       out_next_pc
);

  word_t opb;
  word_t alu_val;
  word_t pc_plus4;
  word_t pc_target;
  word_t result;
  word_t next_pc;
  logic  taken;
  logic  accept;

  assign opb = in_use_imm ? in_imm : in_rs2_val;

  always_comb begin
    case (in_alu_op)
      ALU_SUB:  alu_val = in_rs1_val - opb;
      ALU_SLL:  alu_val = in_rs1_val << opb[4:0];
      ALU_SLT:  alu_val = {31'b0, $signed(in_rs1_val) < $signed(opb)};
      ALU_SLTU: alu_val = {31'b0, in_rs1_val < opb};
      ALU_XOR:  alu_val = in_rs1_val ^ opb;
      ALU_SRL:  alu_val = in_rs1_val >> opb[4:0];
      ALU_SRA:  alu_val = word_t'($signed(in_rs1_val) >>> opb[4:0]);
      ALU_OR:   alu_val = in_rs1_val | opb;
      ALU_AND:  alu_val = in_rs1_val & opb;
      default:  alu_val = in_rs1_val + opb;
    endcase
  end

  always_comb begin
    case (in_funct3)
      3'b000:  taken = (in_rs1_val == in_rs2_val);
      3'b001:  taken = (in_rs1_val != in_rs2_val);
      3'b100:  taken = ($signed(in_rs1_val) < $signed(in_rs2_val));
      3'b101:  taken = ($signed(in_rs1_val) >= $signed(in_rs2_val));
      3'b110:  taken = (in_rs1_val < in_rs2_val);
      3'b111:  taken = (in_rs1_val >= in_rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4  = in_pc + 32'd4;
  assign pc_target = in_pc + in_imm;

  // Loads, stores and JALR get rs1 + imm from the ALU adder
  always_comb begin
    result  = alu_val;
    next_pc = pc_plus4;
    case (in_kind)
      KIND_LUI:   result = in_imm;
      KIND_AUIPC: result = pc_target;
      KIND_JAL: begin
        result  = pc_plus4;
        next_pc = pc_target;
      end
      KIND_JALR: begin
        result  = pc_plus4;
        next_pc = {alu_val[31:1], 1'b0};
      end
      KIND_BRANCH: begin
        if (taken) next_pc = pc_target;
      end
      default: ;
    endcase
  end

  assign in_ready = !out_valid;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_kind       <= in_kind;
      out_rd         <= in_rd;
      out_result     <= result;
      out_store_data <= in_rs2_val;
      out_next_pc    <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- load_store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_unit import cpu_pkg::*; (
  input  wire logic   clk,
  input  wire logic   rst_n,
  input  wire logic   in_valid,
  output logic        in_ready,
  input  instr_kind_e in_kind,
  input  reg_idx_t    in_rd,
  input  word_t       in_result,
  input  word_t       in_store_data,
  input  word_t       in_next_pc,
  output logic        mem_req_valid,
  input  wire logic   mem_req_ready,
  output word_t       mem_req_addr,
  output logic        mem_req_write,
  output word_t       mem_req_wdata,
  input  wire logic   mem_resp_valid,
  input  word_t       mem_resp_rdata,
  output logic        gpr_wen,
  output reg_idx_t    gpr_waddr,
  output word_t       gpr_wdata,
  output logic        commit_valid,
  output word_t       commit_pc,
  output logic        commit_halt
);

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_WAIT,
    L_DONE
  } lsu_state_e;

  lsu_state_e  state;
  instr_kind_e kind_q;
  reg_idx_t    rd_q;
  word_t       result_q;
  word_t       store_data_q;
  word_t       next_pc_q;
  word_t       load_q;
  logic        is_mem;

  assign is_mem   = (in_kind == KIND_LOAD) || (in_kind == KIND_STORE);
  assign in_ready = (state == L_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= L_IDLE;
    end else begin
      case (state)
        L_IDLE: begin
          if (in_valid) state <= is_mem ? L_REQ : L_DONE;
        end
        L_REQ: begin
          if (mem_req_ready) state <= L_WAIT;
        end
        L_WAIT: begin
          if (mem_resp_valid) state <= L_DONE;
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      kind_q       <= in_kind;
      rd_q         <= in_rd;
      result_q     <= in_result;
      store_data_q <= in_store_data;
      next_pc_q    <= in_next_pc;
    end
    if (state == L_WAIT && mem_resp_valid) load_q <= mem_resp_rdata;
  end

  assign mem_req_valid = (state == L_REQ);
  assign mem_req_addr  = result_q;
  assign mem_req_write = (kind_q == KIND_STORE);
  assign mem_req_wdata = store_data_q;

  // No register write for stores, branches and halt
  assign gpr_wen   = (state == L_DONE) && (kind_q != KIND_STORE) &&
                     (kind_q != KIND_BRANCH) && (kind_q != KIND_HALT);
  assign gpr_waddr = rd_q;
  assign gpr_wdata = (kind_q == KIND_LOAD) ? load_q : result_q;

  assign commit_valid = (state == L_DONE);
  assign commit_pc    = next_pc_q;
  assign commit_halt  = (kind_q == KIND_HALT);

endmodule

`default_nettype wire

//--- mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import cpu_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic if_req_valid,
  output logic      if_req_ready,
  input  word_t     if_req_addr,
  output logic      if_resp_valid,
  output word_t     if_resp_rdata,
  input  wire logic ls_req_valid,
  output logic      ls_req_ready,
  input  word_t     ls_req_addr,
  input  wire logic ls_req_write,
  input  word_t     ls_req_wdata,
  output logic      ls_resp_valid,
  output word_t     ls_resp_rdata,
  output logic      mem_req_valid,
  input  wire logic mem_req_ready,
  output word_t     mem_req_addr,
  output logic      mem_req_write,
  output word_t     mem_req_wdata,
  input  wire logic mem_resp_valid,
  input  word_t     mem_resp_rdata
);

  logic busy;
  logic owner_ls;

  // LSU wins when both request in the same cycle
  assign mem_req_valid = !busy && (if_req_valid || ls_req_valid);
  assign mem_req_addr  = ls_req_valid ? ls_req_addr : if_req_addr;
  assign mem_req_write = ls_req_valid && ls_req_write;
  assign mem_req_wdata = ls_req_wdata;

  assign ls_req_ready = !busy && mem_req_ready;
  assign if_req_ready = !busy && !ls_req_valid && mem_req_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      owner_ls <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      busy     <= 1'b1;
      owner_ls <= ls_req_valid;
    end else if (mem_resp_valid) begin
      busy <= 1'b0;
    end
  end

  assign if_resp_valid = mem_resp_valid && busy && !owner_ls;
  assign ls_resp_valid = mem_resp_valid && busy && owner_ls;
  assign if_resp_rdata = mem_resp_rdata;
  assign ls_resp_rdata = mem_resp_rdata;

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
  parameter word_t RESET_PC = '0
) (
  input  wire logic clk,
  input  wire logic rst_n,
  output logic      mem_req_valid,
  input  wire logic mem_req_ready,
  output word_t     mem_req_addr,
  output logic      mem_req_write,
  output word_t     mem_req_wdata,
  input  wire logic mem_resp_valid,
  input  word_t     mem_resp_rdata,
  output logic      halted
);

  // Fetch side of the arbiter
  logic if_req_valid, if_req_ready, if_resp_valid;
  word_t if_req_addr, if_resp_rdata;
  // LSU side of the arbiter
  logic ls_req_valid, ls_req_ready, ls_req_write, ls_resp_valid;
  word_t ls_req_addr, ls_req_wdata, ls_resp_rdata;

  logic fd_valid, fd_ready;
  word_t fd_pc, fd_instr;

  logic de_valid, de_ready, de_use_imm;
  word_t de_pc, de_rs1_val, de_rs2_val, de_imm;
  instr_kind_e de_kind;
  alu_op_e de_alu_op;
  logic [2:0] de_funct3;
  reg_idx_t de_rd;

  logic el_valid, el_ready;
  instr_kind_e el_kind;
  reg_idx_t el_rd;
  word_t el_result, el_store_data, el_next_pc;

  reg_idx_t raddr1, raddr2, gpr_waddr;
  word_t rdata1, rdata2, gpr_wdata;
  logic gpr_wen;

  logic commit_valid, commit_halt;
  word_t commit_pc;

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst_n(rst_n),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_halt(commit_halt),
    .mem_req_valid(if_req_valid), .mem_req_ready(if_req_ready),
    .mem_req_addr(if_req_addr),
    .mem_resp_valid(if_resp_valid), .mem_resp_rdata(if_resp_rdata),
    .out_valid(fd_valid), .out_ready(fd_ready),
    .out_pc(fd_pc), .out_instr(fd_instr),
    .halted(halted)
  );

  decode_unit u_decode (
    .clk(clk), .rst_n(rst_n),
    .in_valid(fd_valid), .in_ready(fd_ready),
    .in_pc(fd_pc), .in_instr(fd_instr),
    .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2),
    .out_valid(de_valid), .out_ready(de_ready),
    .out_pc(de_pc), .out_kind(de_kind), .out_alu_op(de_alu_op),
    .out_funct3(de_funct3), .out_rs1_val(de_rs1_val), .out_rs2_val(de_rs2_val),
    .out_imm(de_imm), .out_use_imm(de_use_imm), .out_rd(de_rd)
  );

  execute_unit u_execute (
    .clk(clk), .rst_n(rst_n),
    .in_valid(de_valid), .in_ready(de_ready),
    .in_pc(de_pc), .in_kind(de_kind), .in_alu_op(de_alu_op),
    .in_funct3(de_funct3), .in_rs1_val(de_rs1_val), .in_rs2_val(de_rs2_val),
    .in_imm(de_imm), .in_use_imm(de_use_imm), .in_rd(de_rd),
    .out_valid(el_valid), .out_ready(el_ready),
    .out_kind(el_kind), .out_rd(el_rd), .out_result(el_result),
    .out_store_data(el_store_data), .out_next_pc(el_next_pc)
  );

  load_store_unit u_lsu (
    .clk(clk), .rst_n(rst_n),
    .in_valid(el_valid), .in_ready(el_ready),
    .in_kind(el_kind), .in_rd(el_rd), .in_result(el_result),
    .in_store_data(el_store_data), .in_next_pc(el_next_pc),
    .mem_req_valid(ls_req_valid), .mem_req_ready(ls_req_ready),
    .mem_req_addr(ls_req_addr), .mem_req_write(ls_req_write),
    .mem_req_wdata(ls_req_wdata),
    .mem_resp_valid(ls_resp_valid), .mem_resp_rdata(ls_resp_rdata),
    .gpr_wen(gpr_wen), .gpr_waddr(gpr_waddr), .gpr_wdata(gpr_wdata),
    .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_halt(commit_halt)
  );

  gpr_file u_gpr (
    .clk(clk), .rst_n(rst_n),
    .raddr1(raddr1), .raddr2(raddr2),
    .wen(gpr_wen), .waddr(gpr_waddr), .wdata(gpr_wdata),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst_n(rst_n),
    .if_req_valid(if_req_valid), .if_req_ready(if_req_ready),
    .if_req_addr(if_req_addr),
    .if_resp_valid(if_resp_valid), .if_resp_rdata(if_resp_rdata),
    .ls_req_valid(ls_req_valid), .ls_req_ready(ls_req_ready),
    .ls_req_addr(ls_req_addr), .ls_req_write(ls_req_write),
    .ls_req_wdata(ls_req_wdata),
    .ls_resp_valid(ls_resp_valid), .ls_resp_rdata(ls_resp_rdata),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_req_addr(mem_req_addr), .mem_req_write(mem_req_write),
    .mem_req_wdata(mem_req_wdata),
    .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata)
  );

endmodule

`default_nettype wire

//--- cpu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic mem_req_valid,
  input wire logic mem_req_ready,
  input word_t     mem_req_addr,
  input wire logic mem_req_write,
  input word_t     mem_req_wdata,
  input wire logic mem_resp_valid,
  input wire logic halted
);

  int   fail_count;
  logic outstanding;

  initial fail_count = 0;

  // Open request on the external port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 1'b0;
    end else if (mem_req_valid && mem_req_ready) begin
      outstanding <= 1'b1;
    end else if (mem_resp_valid) begin
      outstanding <= 1'b0;
    end
  end

  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr) &&
      $stable(mem_req_write) && (!mem_req_write || $stable(mem_req_wdata)))
  else begin
    fail_count++;
    $error("External request changed while stalled");
  end

  no_req_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    halted |-> !mem_req_valid)
  else begin
    fail_count++;
    $error("Request raised while halted");
  end

  resp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    mem_resp_valid |-> outstanding)
  else begin
    fail_count++;
    $error("Response without an outstanding request");
  end

endmodule

bind cpu_top cpu_assertions u_assertions (
  .clk(clk),
  .rst_n(rst_n),
  .mem_req_valid(mem_req_valid),
  .mem_req_ready(mem_req_ready),
  .mem_req_addr(mem_req_addr),
  .mem_req_write(mem_req_write),
  .mem_req_wdata(mem_req_wdata),
  .mem_resp_valid(mem_resp_valid),
  .halted(halted)
);

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam word_t RESET_PC        = 32'h0000_0000;
  localparam int    NUM_PROGS       = 20;
  localparam int    PROG_LEN        = 40;
  localparam int    INSTR_PER_PROG  = PROG_LEN + 33;
  localparam int    MEM_WORDS       = 512;
  localparam word_t DATA_BASE       = 32'h0000_0400;
  localparam word_t DUMP_BASE       = 32'h0000_0500;
  localparam int    WATCHDOG_CYCLES = NUM_PROGS * (INSTR_PER_PROG * 20 + 16);

  logic  clk;
  logic  rst_n;
  logic  mem_req_valid;
  logic  mem_req_ready;
  logic  mem_req_write;
  logic  mem_resp_valid;
  logic  halted;
  word_t mem_req_addr;
  word_t mem_req_wdata;
  word_t mem_resp_rdata;

  word_t mem [MEM_WORDS];
  word_t ref_mem [MEM_WORDS];
  // Expected order of every accepted request, fetches included
  logic  exp_write [$];
  word_t exp_addr [$];
  word_t exp_data [$];

  logic  pending;
  int    resp_delay;
  word_t resp_data;

  cpu_top #(.RESET_PC(RESET_PC)) i_dut (
    .clk(clk), .rst_n(rst_n),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
    .mem_req_addr(mem_req_addr), .mem_req_write(mem_req_write),
    .mem_req_wdata(mem_req_wdata),
    .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata),
    .halted(halted)
  );

  always #4 clk = ~clk;

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_addr(word_t got, word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: request address is %h, expected %h", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_write(logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: request write flag is %b, expected %b", $time, got, exp);
      stop_run();
    end
  endtask

  task automatic check_halt(logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: halted is %b, expected %b", $time, got, exp);
      stop_run();
    end
  endtask

  function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                   reg_idx_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t j_type(logic [20:0] off, reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // Targets always lie ahead of idx and no further than the register dump
  function automatic word_t gen_instr(int idx);
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] f3;
    logic [2:0] bf3;
    logic [4:0] shamt;
    logic [6:0] f7;
    int         hop;
    word_t      off;
    word_t      w;
    rd    = reg_idx_t'($urandom_range(0, 31));
    rs1   = reg_idx_t'($urandom_range(0, 31));
    rs2   = reg_idx_t'($urandom_range(0, 31));
    f3    = 3'($urandom_range(0, 7));
    bf3   = 3'($urandom_range(0, 5));
    shamt = 5'($urandom_range(0, 31));
    f7    = ($urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
    hop   = $urandom_range(1, PROG_LEN - idx);
    off   = word_t'(hop * 4);
    if (bf3 >= 3'd2) bf3 = bf3 + 3'd2;
    case ($urandom_range(0, 15))
      0, 1, 2, 3: w = r_type((f3 == 3'd0 || f3 == 3'd5) ? f7 : 7'h00, rs2, rs1, f3, rd);
      4, 5, 6: begin
        if (f3 == 3'd1) w = i_type({7'h00, shamt}, rs1, f3, rd, OPC_OPIMM);
        else if (f3 == 3'd5) w = i_type({f7, shamt}, rs1, f3, rd, OPC_OPIMM);
        else w = i_type(12'($urandom), rs1, f3, rd, OPC_OPIMM);
      end
      7:       w = {20'($urandom), rd, OPC_LUI};
      8:       w = {20'($urandom), rd, OPC_AUIPC};
      9:       w = i_type(12'(DATA_BASE + 4 * $urandom_range(0, 63)), 5'd0, 3'b010, rd,
                          OPC_LOAD);
      10, 11:  w = s_type(12'(DATA_BASE + 4 * $urandom_range(0, 63)), rs2, 5'd0);
      12, 13:  w = b_type(off[12:0], rs2, rs1, bf3);
      14:      w = j_type(off[20:0], rd);
      default: w = i_type(12'(RESET_PC + 4 * (idx + hop)), 5'd0, 3'b000, rd, OPC_JALR);
    endcase
    return w;
  endfunction

  task automatic build_program();
    int    base;
    word_t a;
    base = RESET_PC / 4;
    for (int i = 0; i < MEM_WORDS; i++) begin
      a      = word_t'(i * 4);
      mem[i] = (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      mem[base + i] = gen_instr(i);
    end
    // Dump every register, x0 too, then EBREAK
    for (int r = 0; r < 32; r++) begin
      mem[base + PROG_LEN + r] = s_type(12'(DUMP_BASE + 4 * r), reg_idx_t'(r), 5'd0);
    end
    mem[base + PROG_LEN + 32] = 32'h0010_0073;
    ref_mem = mem;
  endtask

  function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Instruction-set model, builds the expected request sequence
  task automatic run_model();
    word_t      x [32];
    word_t      pc;
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      addr;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      next_pc;
    logic [2:0] f3;
    reg_idx_t   rd;
    logic       do_wr;
    logic       taken;
    logic       done;
    int         steps;
    exp_write.delete();
    exp_addr.delete();
    exp_data.delete();
    foreach (x[i]) x[i] = '0;
    pc    = RESET_PC;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 4 * INSTR_PER_PROG) begin
      exp_write.push_back(1'b0);
      exp_addr.push_back(pc);
      exp_data.push_back('0);
      ins     = ref_mem[pc[31:2]];
      rd      = ins[11:7];
      f3      = ins[14:12];
      a       = x[ins[19:15]];
      b       = x[ins[24:20]];
      imm_i   = {{20{ins[31]}}, ins[31:20]};
      imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      next_pc = pc + 32'd4;
      do_wr   = 1'b1;
      res     = '0;
      case (ins[6:0])
        OPC_LUI:   res = {ins[31:12], 12'b0};
        OPC_AUIPC: res = pc + {ins[31:12], 12'b0};
        OPC_JAL: begin
          res     = pc + 32'd4;
          next_pc = pc + imm_j;
        end
        OPC_JALR: begin
          res     = pc + 32'd4;
          next_pc = (a + imm_i) & ~32'd1;
        end
        OPC_BRANCH: begin
          do_wr = 1'b0;
          case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = ($signed(a) >= $signed(b));
            3'd6:    taken = (a < b);
            default: taken = (a >= b);
          endcase
          if (taken) next_pc = pc + imm_b;
        end
        OPC_LOAD: begin
          addr = a + imm_i;
          exp_write.push_back(1'b0);
          exp_addr.push_back(addr);
          exp_data.push_back('0);
          res = ref_mem[addr[31:2]];
        end
        OPC_STORE: begin
          do_wr = 1'b0;
          addr  = a + imm_s;
          exp_write.push_back(1'b1);
          exp_addr.push_back(addr);
          exp_data.push_back(b);
          ref_mem[addr[31:2]] = b;
        end
        OPC_OPIMM: res = model_alu(f3, (f3 == 3'd5) && ins[30], a, imm_i);
        OPC_OP:    res = model_alu(f3, ins[30], a, b);
        default: begin
          do_wr = 1'b0;
          done  = 1'b1;
        end
      endcase
      if (do_wr && rd != 5'd0) x[rd] = res;
      pc    = next_pc;
      steps = steps + 1;
    end
    if (!done) fail_run("Reference model never reached EBREAK");
  endtask

  task automatic serve_request();
    logic  w;
    word_t a;
    word_t d;
    if (exp_addr.size() == 0) begin
      fail_run("Memory request seen after the program should have ended");
    end else begin
      w = exp_write.pop_front();
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      check_addr(mem_req_addr, a);
      check_write(mem_req_write, w);
      if (w) begin
        check_word("store data", mem_req_wdata, d);
        mem[mem_req_addr[31:2]] = mem_req_wdata;
        resp_data = '0;
      end else begin
        resp_data = mem[mem_req_addr[31:2]];
      end
      pending    = 1'b1;
      resp_delay = $urandom_range(1, 4);
    end
  endtask

  // Request side of the memory model, taken in the middle of the cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (halted && mem_req_valid) fail_run("Memory request raised while the core is halted");
      if (mem_req_valid && mem_req_ready) serve_request();
    end
  end

  always @(negedge clk) begin
    if (i_dut.u_assertions.fail_count != 0) begin
      fail_run("A bound assertion on the memory port failed");
    end
  end

  // Response side of the memory model with random stalls and delays
  always @(posedge clk) begin
    if (!rst_n) begin
      #1;
      mem_req_ready  = 1'b0;
      mem_resp_valid = 1'b0;
      mem_resp_rdata = '0;
      pending        = 1'b0;
    end else begin
      #1;
      mem_resp_valid = 1'b0;
      if (pending) begin
        if (resp_delay == 1) begin
          mem_resp_valid = 1'b1;
          mem_resp_rdata = resp_data;
          pending        = 1'b0;
        end else begin
          resp_delay = resp_delay - 1;
        end
      end
      mem_req_ready = ($urandom_range(0, 3) != 0);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the programs did not all reach EBREAK",
             WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    pending        = 1'b0;
    resp_delay     = 0;
    resp_data      = '0;
    void'($urandom(32'h3129_ad3b));
    for (int p = 0; p < NUM_PROGS; p++) begin
      rst_n = 1'b0;
      build_program();
      run_model();
      repeat (2) begin
        @(posedge clk);
        #1;
      end
      check_halt(halted, 1'b0);
      rst_n = 1'b1;
      do begin
        @(posedge clk);
        #1;
      end while (!halted);
      // Linger so that a late request would show up
      repeat (10) begin
        @(posedge clk);
        #1;
      end
      check_halt(halted, 1'b1);
      if (exp_addr.size() != 0) begin
        fail_run("Core halted before making all expected memory requests");
      end
    end
    if (i_dut.u_assertions.fail_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

`default_nettype wire

//--- build.f
cpu_pkg.sv
gpr_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
load_store_unit.sv
mem_arbiter.sv
cpu_top.sv
cpu_assertions.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - cpu_pkg.sv
  - gpr_file.sv
  - fetch_unit.sv
  - decode_unit.sv
  - execute_unit.sv
  - load_store_unit.sv
  - mem_arbiter.sv
  - cpu_top.sv
  - target: test
    files:
      - cpu_assertions.sv
      - tb_cpu.sv
